// ==== test/dbg_stim.txt ====
# cmd name char_hex exp_motor exp_datalog | frame name ts_hex acc_hex gyr_hex busy_pct
# pair name ts acc gyr ts2 acc2 gyr2 busy_pct (second snapshot sent twice)
frame zero_frame 000000 000000000000 000000000000 0
frame ts_123456 01e240 000000000000 000000000000 0
frame ts_max ffffff a5a5ffff0f0f 123456789abc 0
frame fields_busy 0003e8 c3b2a1d4e5f6 0718293a4b5c 40
cmd arm_motor 6d 1 0
cmd log_on 64 1 1
cmd unknown_q 71 1 1
frame flags_ar 0f423f 8001ffff7e00 ff00aa5501fe 25
cmd board_rst 72 0 0
cmd arm_again 6d 1 0
pair tmr_overlap 00bc61 123456789abc fedcba987654 00002a 5a5a5a5a5a5a a5a5a5a5a5a5 30

// ==== flist.f ====
+incdir+include
hdl/dbg_pkg.sv
hdl/ts_bcd_convert.sv
hdl/dbg_frame_format.sv
hdl/dbg_tx_serializer.sv
hdl/dbg_cmd_decode.sv
hdl/dbg_terminal.sv
test/tb_dbg_terminal.sv

// ==== Bender.yml ====
package:
  name: dbg_terminal
export_include_dirs:
  - include
sources:
  - hdl/dbg_pkg.sv
  - hdl/ts_bcd_convert.sv
  - hdl/dbg_frame_format.sv
  - hdl/dbg_tx_serializer.sv
  - hdl/dbg_cmd_decode.sv
  - hdl/dbg_terminal.sv
  - target: test
    files:
      - test/tb_dbg_terminal.sv

// ==== test/tb_dbg_terminal.sv ====
//////////////////////////////
// Debug terminal testbench
// Stim file player, frame model, byte monitor
//////////////////////////////
`timescale 1ns/1ns
`include "dbg_consts.svh"

module tb_dbg_terminal;
  import dbg_pkg::*;

  logic        clk;
  logic        rst = 1'b1;
  logic        tmr = 1'b0;
  dbg_sample_t sample = '0;
  char_t       rx_data = '0;
  logic        new_rx_data = 1'b0;
  logic        tx_busy = 1'b0;
  char_t       tx_data;
  logic        new_tx_data, motor_armed, datalog_on, board_reset_req;
  integer      seed = 32'hf9a7c750;
  int          busy_pct = 0;
  // Bytes still owed by the DUT in arrival order
  char_t       exp_q[$];
  char_t       exp_b;
  // Flag model as the cmd lines leave it
  logic        motor_m = 1'b0;
  logic        data_m = 1'b0;
  string       cur_name = "reset";
  time         wd_deadline = 1000;

  dbg_terminal i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic fail_run();
    $display("TEST FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_val(input string what, input logic [7:0] exp, input logic [7:0] act);
    assert (act == exp) else begin
      $display("error %s %s expected %h actual %h", cur_name, what, exp, act);
      fail_run();
    end
  endtask

  task automatic check_flags(input logic m, input logic d, input logic r);
    check_val("motor_armed", m, motor_armed);
    check_val("datalog_on", d, datalog_on);
    check_val("board_reset_req", r, board_reset_req);
  endtask

  // 200 cycles per frame plus 64 bytes stretched by the busy density
  task automatic arm_watchdog(input int frames, input int pct);
    wd_deadline = $time + 8 * frames * (200 + 100 * `DBG_MSG_LEN / (100 - pct));
  endtask

  initial begin : watchdog
    while ($time < wd_deadline) begin
      @(posedge clk);
    end
    $display("timeout: %s did not finish within its cycle budget", cur_name);
    fail_run();
  end

  // Expected frame from the layout rule with flag letters from the model
  task automatic push_frame(input dbg_sample_t s);
    logic [47:0] hi;
    hi = {s.acc[47:40], s.acc[31:24], s.acc[15:8],
          s.gyr[47:40], s.gyr[31:24], s.gyr[15:8]};
    exp_q.push_back(" ");
    // Digits 5 to 2 with the dot in front of digit 2
    for (int k = 5; k >= 2; k--) begin
      if (k == 2) begin
        exp_q.push_back(".");
      end
      exp_q.push_back(char_t'(48 + (s.ts / 10 ** k) % 10));
    end
    exp_q.push_back(" ");
    for (int i = 47; i >= 0; i--) begin
      exp_q.push_back(hi[i] ? "1" : "0");
      // Space closes each field and the last one sits at 60
      if (i % 8 == 0) begin
        exp_q.push_back(" ");
      end
    end
    exp_q.push_back(motor_m ? "A" : "D");
    exp_q.push_back(data_m ? "R" : "I");
    exp_q.push_back(8'h0d);
  endtask

  task automatic pulse_tmr(input dbg_sample_t s);
    @(posedge clk);
    sample <= s;
    tmr    <= 1'b1;
    @(posedge clk);
    tmr <= 1'b0;
  endtask

  // Old flags one cycle after the strobe and new ones the cycle after
  task automatic send_cmd(input char_t ch, input logic em, input logic ed);
    @(posedge clk);
    rx_data     <= ch;
    new_rx_data <= 1'b1;
    @(posedge clk);
    new_rx_data <= 1'b0;
    @(posedge clk);
    check_flags(motor_m, data_m, 1'b0);
    @(posedge clk);
    check_flags(em, ed, ch == "r");
    @(posedge clk);
    check_flags(em, ed, 1'b0);
    motor_m = em;
    data_m  = ed;
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    // Room for a stray conversion to reach the wire
    repeat (40) @(posedge clk);
  endtask

  // Every strobed byte against the head of the queue
  always @(posedge clk) begin
    if (!rst && new_tx_data) begin
      check_val("tx_busy at strobe", 8'd0, tx_busy);
      assert (exp_q.size() != 0) else begin
        $display("the DUT sent a byte beyond the expected frames in %s", cur_name);
        fail_run();
      end
      exp_b = exp_q.pop_front();
      check_val($sformatf("byte %0d", 63 - exp_q.size() % 64), exp_b, tx_data);
    end
  end

  // Bridge back-pressure at the density of the current line
  always @(posedge clk) begin
    tx_busy <= !rst && (($random(seed) & 32'h7fffffff) % 100 < busy_pct);
  end

  initial begin
    int      fd, pct, em, ed;
    string   line, op;
    char_t   ch;
    ts_t     ts1, ts2;
    sensor_t acc1, gyr1, acc2, gyr2;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    // Quiet bridge and clear flags out of reset
    check_flags(1'b0, 1'b0, 1'b0);
    check_val("new_tx_data", 8'd0, new_tx_data);
    fd = $fopen("test/dbg_stim.txt", "r");
    if (fd == 0) begin
      $display("cannot open test/dbg_stim.txt");
      fail_run();
    end
    while ($fgets(line, fd) != 0) begin
      op = "";
      void'($sscanf(line, "%s", op));
      if (op == "cmd") begin
        void'($sscanf(line, "%s %s %h %d %d", op, cur_name, ch, em, ed));
        arm_watchdog(1, 0);
        send_cmd(ch, em[0], ed[0]);
      end else if (op == "frame") begin
        void'($sscanf(line, "%s %s %h %h %h %d", op, cur_name, ts1, acc1, gyr1, pct));
        arm_watchdog(1, pct);
        busy_pct <= pct;
        push_frame({ts1, acc1, gyr1});
        pulse_tmr({ts1, acc1, gyr1});
        wait_drain();
      end else if (op == "pair") begin
        void'($sscanf(line, "%s %s %h %h %h %h %h %h %d", op, cur_name,
                      ts1, acc1, gyr1, ts2, acc2, gyr2, pct));
        arm_watchdog(2, pct);
        busy_pct <= pct;
        push_frame({ts1, acc1, gyr1});
        push_frame({ts2, acc2, gyr2});
        pulse_tmr({ts1, acc1, gyr1});
        // Lands mid conversion with a snapshot no frame may show
        repeat (4) @(posedge clk);
        pulse_tmr(~{ts2, acc2, gyr2});
        // First frame is on the wire by now so this pulse is taken
        repeat (40) @(posedge clk);
        pulse_tmr({ts2, acc2, gyr2});
        wait_drain();
      end
    end
    $fclose(fd);
    cur_name = "end of run";
    arm_watchdog(1, 0);
    repeat (60) @(posedge clk);
    if (exp_q.size() == 0) begin
      $display("TEST PASSED");
      $finish;
    end else begin
      $display("%0d expected frame bytes never arrived", exp_q.size());
      fail_run();
    end
  end

endmodule

// ==== hdl/dbg_terminal.sv ====
//////////////////////////////
// Debug terminal top level
// Three frame stages plus command path
//////////////////////////////
`timescale 1ns/1ns

module dbg_terminal (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 tmr,
  input  dbg_pkg::dbg_sample_t sample,
  input  dbg_pkg::char_t       rx_data,
  input  logic                 new_rx_data,
  input  logic                 tx_busy,
  output dbg_pkg::char_t       tx_data,
  output logic                 new_tx_data,
  output logic                 motor_armed,
  output logic                 datalog_on,
  output logic                 board_reset_req
);
  import dbg_pkg::*;

  // Stage 1 to stage 2
  logic      conv_valid;
  logic      conv_ready;
  dbg_conv_t conv;
  // Stage 2 to stage 3
  logic      frame_start;
  logic      tx_idle;
  msg_idx_t  msg_idx;

  ts_bcd_convert i_conv (
    .clk, .rst, .tmr, .sample, .conv_ready, .conv_valid, .conv
  );

  // Character for the current position goes straight to the bridge
  dbg_frame_format i_fmt (
    .clk, .rst, .conv_valid, .conv, .conv_ready, .tx_idle,
    .motor_armed, .datalog_on, .frame_start, .msg_idx,
    .msg_char (tx_data)
  );

  dbg_tx_serializer i_tx (
    .clk, .rst, .frame_start, .tx_busy, .msg_idx, .tx_idle, .new_tx_data
  );

  dbg_cmd_decode i_cmd (
    .clk, .rst, .rx_data, .new_rx_data, .motor_armed, .datalog_on, .board_reset_req
  );

endmodule

// ==== hdl/dbg_cmd_decode.sv ====
//////////////////////////////
// Terminal command decoder
// m motor, d datalog, r reset
//////////////////////////////
`timescale 1ns/1ns

module dbg_cmd_decode (
  input  logic           clk,
  input  logic           rst,
  input  dbg_pkg::char_t rx_data,
  input  logic           new_rx_data,
  output logic           motor_armed,
  output logic           datalog_on,
  output logic           board_reset_req
);
  import dbg_pkg::*;

  cmd_state_t state_q;
  cmd_state_t state_d;

  // Action states last one cycle
  always_comb begin
    state_d = CMD_IDLE;
    if (state_q == CMD_IDLE && new_rx_data) begin
      case (rx_data)
        "m":     state_d = CMD_MOTOR;
        "d":     state_d = CMD_DATA;
        "r":     state_d = CMD_RESET;
        // Unknown characters dropped
        default: state_d = CMD_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q         <= CMD_IDLE;
      motor_armed     <= 1'b0;
      datalog_on      <= 1'b0;
      board_reset_req <= 1'b0;
    end else begin
      state_q         <= state_d;
      board_reset_req <= state_q == CMD_RESET;
      case (state_q)
        CMD_MOTOR: motor_armed <= ~motor_armed;
        CMD_DATA:  datalog_on  <= ~datalog_on;
        // Board reset also disarms and stops logging
        CMD_RESET: begin
          motor_armed <= 1'b0;
          datalog_on  <= 1'b0;
        end
        default: ;
      endcase
    end
  end

endmodule

// ==== hdl/dbg_tx_serializer.sv ====
//////////////////////////////
// Stage 3: byte walker toward
// the USB serial bridge
//////////////////////////////
`timescale 1ns/1ns
`include "dbg_consts.svh"

module dbg_tx_serializer (
  input  logic              clk,
  input  logic              rst,
  input  logic              frame_start,
  input  logic              tx_busy,
  output dbg_pkg::msg_idx_t msg_idx,
  output logic              tx_idle,
  output logic              new_tx_data
);
  import dbg_pkg::*;

  tx_state_t state_q;
  msg_idx_t  idx_q;
  logic      last;

  assign last = idx_q == msg_idx_t'(`DBG_MSG_LEN - 1);

  // Strobe whenever the bridge can take a byte
  assign new_tx_data = (state_q == TX_SEND) && !tx_busy;
  assign tx_idle     = state_q == TX_IDLE;
  assign msg_idx     = idx_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= TX_IDLE;
      idx_q   <= '0;
    end else begin
      case (state_q)
        TX_IDLE: begin
          idx_q <= '0;
          if (frame_start) begin
            state_q <= TX_SEND;
          end
        end
        TX_SEND: begin
          if (!tx_busy) begin
            idx_q <= idx_q + 1'b1;
            // CR sent, frame done
            if (last) begin
              state_q <= TX_IDLE;
            end
          end
        end
        default: state_q <= TX_IDLE;
      endcase
    end
  end

endmodule

// ==== hdl/dbg_frame_format.sv ====
//////////////////////////////
// Stage 2: frame holding register
// and position to ASCII mapping
//////////////////////////////
`timescale 1ns/1ns

module dbg_frame_format (
  input  logic               clk,
  input  logic               rst,
  input  logic               conv_valid,
  input  dbg_pkg::dbg_conv_t conv,
  output logic               conv_ready,
  input  logic               tx_idle,
  input  logic               motor_armed,
  input  logic               datalog_on,
  output logic               frame_start,
  input  dbg_pkg::msg_idx_t  msg_idx,
  output dbg_pkg::char_t     msg_char
);
  import dbg_pkg::*;

  dbg_conv_t      conv_q;
  char_t          motor_chr_q;
  char_t          data_chr_q;
  logic           xfer;
  // Six high bytes, field 0 first
  logic [0:5][7:0] hi_bytes;
  msg_idx_t       rel;
  logic [2:0]     fld;
  logic [3:0]     off;

  function automatic char_t digit_chr(input logic [3:0] d);
    return char_t'("0") + char_t'(d);
  endfunction

  // Serializer busy or about to start, hold off stage 1
  assign conv_ready = tx_idle && !frame_start;
  assign xfer       = conv_valid && conv_ready;

  // Snapshot and flag letters stay for a whole frame
  always_ff @(posedge clk) begin
    if (xfer) begin
      conv_q      <= conv;
      motor_chr_q <= motor_armed ? "A" : "D";
      data_chr_q  <= datalog_on ? "R" : "I";
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      frame_start <= 1'b0;
    end else begin
      frame_start <= xfer;
    end
  end

  assign hi_bytes = {conv_q.acc[47:40], conv_q.acc[31:24], conv_q.acc[15:8],
                     conv_q.gyr[47:40], conv_q.gyr[31:24], conv_q.gyr[15:8]};

  // Fields are 9 wide from position 7, offset 8 is the separator
  assign rel = msg_idx - msg_idx_t'(7);
  assign fld = 3'(rel / 6'd9);
  assign off = 4'(rel % 6'd9);

  always_comb begin
    case (msg_idx)
      6'd0:    msg_char = " ";
      // Digits 5,4,3 . 2
      6'd1:    msg_char = digit_chr(conv_q.bcd[23:20]);
      6'd2:    msg_char = digit_chr(conv_q.bcd[19:16]);
      6'd3:    msg_char = digit_chr(conv_q.bcd[15:12]);
      6'd4:    msg_char = ".";
      6'd5:    msg_char = digit_chr(conv_q.bcd[11:8]);
      6'd6:    msg_char = " ";
      6'd61:   msg_char = motor_chr_q;
      6'd62:   msg_char = data_chr_q;
      6'd63:   msg_char = 8'h0d;
      default: begin
        // Covers the spaces at 15..51 and 60 too
        if (off == 4'd8) begin
          msg_char = " ";
        end else begin
          msg_char = hi_bytes[fld][3'd7 - off[2:0]] ? "1" : "0";
        end
      end
    endcase
  end

endmodule

// ==== hdl/ts_bcd_convert.sv ====
//////////////////////////////
// Stage 1: snapshot latch and
// binary to BCD timestamp conversion
//////////////////////////////
`timescale 1ns/1ns
`include "dbg_consts.svh"

module ts_bcd_convert (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 tmr,
  input  dbg_pkg::dbg_sample_t sample,
  input  logic                 conv_ready,
  output logic                 conv_valid,
  output dbg_pkg::dbg_conv_t   conv
);
  import dbg_pkg::*;

  localparam int STEP_W = $clog2(`DBG_CONV_STEPS + 1);

  logic              busy_q;
  logic [STEP_W-1:0] step_q;
  ts_t               ts_sr_q;
  bcd_t              bcd_q;
  sensor_t           acc_q;
  sensor_t           gyr_q;
  bcd_t              bcd_adj;
  logic              start;
  logic              iterate;

  // Only take a snapshot with nothing converting or waiting
  assign start   = tmr && !busy_q && !conv_valid;
  // Last busy cycle is the result cycle, no shift
  assign iterate = busy_q && (step_q != STEP_W'(`DBG_CONV_STEPS));

  // Add 3 to every digit of 5 or more before the shift
  always_comb begin
    bcd_adj = bcd_q;
    for (int i = 0; i < `DBG_BCD_DIGITS; i++) begin
      if (bcd_q[4*i +: 4] >= 4'd5) begin
        bcd_adj[4*i +: 4] = bcd_q[4*i +: 4] + 4'd3;
      end
    end
  end

  // Control: busy, step count, result valid
  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q     <= 1'b0;
      step_q     <= '0;
      conv_valid <= 1'b0;
    end else if (start) begin
      busy_q <= 1'b1;
      step_q <= '0;
    end else if (iterate) begin
      step_q <= step_q + 1'b1;
    end else if (busy_q) begin
      // Result cycle
      busy_q     <= 1'b0;
      conv_valid <= 1'b1;
    end else if (conv_valid && conv_ready) begin
      conv_valid <= 1'b0;
    end
  end

  // Datapath, timestamp shifts MSB first into the BCD accumulator
  always_ff @(posedge clk) begin
    if (start) begin
      ts_sr_q <= sample.ts;
      bcd_q   <= '0;
      acc_q   <= sample.acc;
      gyr_q   <= sample.gyr;
    end else if (iterate) begin
      bcd_q   <= {bcd_adj[$bits(bcd_t)-2:0], ts_sr_q[$bits(ts_t)-1]};
      ts_sr_q <= ts_sr_q << 1;
    end
  end

  // Registers hold still until the transfer
  assign conv.bcd = bcd_q;
  assign conv.acc = acc_q;
  assign conv.gyr = gyr_q;

endmodule

// ==== hdl/dbg_pkg.sv ====
//////////////////////////////
// Debug terminal types
// Vectors, snapshot structs, FSM states
//////////////////////////////
`include "dbg_consts.svh"

package dbg_pkg;

  typedef logic [7:0] char_t;
  typedef logic [`DBG_TS_BITS-1:0] ts_t;
  // Digit 0 in the low nibble
  typedef logic [4*`DBG_BCD_DIGITS-1:0] bcd_t;
  typedef logic [`DBG_SENSOR_BITS-1:0] sensor_t;
  typedef logic [$clog2(`DBG_MSG_LEN)-1:0] msg_idx_t;

  // Raw snapshot from the board
  typedef struct packed {
    ts_t     ts;
    sensor_t acc;
    sensor_t gyr;
  } dbg_sample_t;

  // Snapshot after timestamp conversion
  typedef struct packed {
    bcd_t    bcd;
    sensor_t acc;
    sensor_t gyr;
  } dbg_conv_t;

  typedef enum logic [1:0] {CMD_IDLE, CMD_RESET, CMD_MOTOR, CMD_DATA} cmd_state_t;
  typedef enum logic {TX_IDLE, TX_SEND} tx_state_t;

endpackage

// ==== include/dbg_consts.svh ====
//////////////////////////////
// Debug terminal constants
// Frame, timestamp, BCD and sensor sizes
//////////////////////////////
`ifndef DBG_CONSTS_SVH
`define DBG_CONSTS_SVH

// Characters per frame, CR included
`define DBG_MSG_LEN 64

// Millisecond timestamp width
`define DBG_TS_BITS 24

// Decimal digits out of the converter
`define DBG_BCD_DIGITS 8

// One three-axis sample, 16 bits per axis
`define DBG_SENSOR_BITS 48

// One shift-and-add-3 step per timestamp bit
`define DBG_CONV_STEPS `DBG_TS_BITS

`endif
